// ==== logic/lab_params.svh ====
`ifndef LAB_PARAMS_SVH
`define LAB_PARAMS_SVH

// keyboard FIFO depth, power of two
`define LAB_KBD_FIFO_DEPTH 8

// loaded when the shift register sits at zero
`define LAB_LFSR_SEED 8'h01

// active-low segments, so all ones is dark
`define LAB_SEG_BLANK 8'hff

// PS/2 key release prefix
`define LAB_BREAK_CODE 8'hf0

`endif

// ==== logic/lab_pkg.sv ====
`default_nettype none

package lab_pkg;

    // experiment routed to leds and digits
    typedef enum logic [1:0] {
        mode_alu,
        mode_shift,
        mode_random,
        mode_keyboard
    } lab_mode_e;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_not,
        op_and,
        op_or,
        op_xor,
        op_less,
        op_equal
    } alu_op_e;

    typedef struct packed {
        logic [3:0] res;
        logic       zero;
        logic       ovfl;
        logic       carry;
    } alu_result_t;

    typedef struct packed {
        logic [7:0] din;
        logic [2:0] shamt;
        logic       left;
        logic       arith;
    } shift_ctrl_t;

    // data is the FIFO head
    typedef struct packed {
        logic [7:0] data;
        logic       ready;
        logic       overflow;
    } kbd_status_t;

    typedef struct packed {
        logic [7:0] digit7;
        logic [7:0] digit6;
        logic [7:0] digit5;
        logic [7:0] digit4;
        logic [7:0] digit3;
        logic [7:0] digit2;
        logic [7:0] digit1;
        logic [7:0] digit0;
    } seg_bank_t;

endpackage

`default_nettype wire

// ==== logic/lab_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module lab_alu (
    input  wire [3:0]             a,
    input  wire [3:0]             b,
    input  wire lab_pkg::alu_op_e op,
    output lab_pkg::alu_result_t  result
);

    logic [4:0] sum;
    logic [4:0] diff;
    logic [3:0] res;
    logic       zero;
    logic       ovfl;
    logic       carry;

    // five bits wide so the top bit is carry or borrow
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // zero decided per operation from the operands
    always_comb begin
        res   = 4'd0;
        zero  = 1'b1;
        ovfl  = 1'b0;
        carry = 1'b0;
        case (op)
            lab_pkg::op_add: begin
                res   = sum[3:0];
                zero  = (a == (4'd0 - b));
                carry = sum[4];
                ovfl  = (a[3] == b[3]) && (sum[3] != a[3]);
            end
            lab_pkg::op_sub: begin
                res   = diff[3:0];
                zero  = (a == b);
                carry = diff[4];
                // operands of opposite sign, result sign flipped
                ovfl  = (a[3] != b[3]) && (diff[3] != a[3]);
            end
            lab_pkg::op_not: begin
                res  = ~a;
                zero = (a == 4'hf);
            end
            lab_pkg::op_and: begin
                res  = a & b;
                zero = ((a & b) == 4'd0);
            end
            lab_pkg::op_or: begin
                res  = a | b;
                zero = (a == 4'd0) && (b == 4'd0);
            end
            lab_pkg::op_xor: begin
                res  = a ^ b;
                zero = (a == b);
            end
            lab_pkg::op_less: begin
                res  = {3'b000, $signed(a) < $signed(b)};
                zero = ($signed(a) >= $signed(b));
            end
            lab_pkg::op_equal: begin
                res  = {3'b000, a == b};
                zero = (a != b);
            end
            default: begin
                res  = 4'd0;
                zero = 1'b1;
            end
        endcase
    end

    assign result.res   = res;
    assign result.zero  = zero;
    assign result.ovfl  = ovfl;
    assign result.carry = carry;

    // flag must track the result on every change of the output bundle
    zero_flag_matches: assert property (
        @(result) !$isunknown(result) |-> (result.zero == (result.res == 4'd0))
    );

endmodule

`default_nettype wire

// ==== logic/barrel_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module barrel_shifter (
    input  wire lab_pkg::shift_ctrl_t ctrl,
    output logic [7:0]                dout
);

    logic       fill;
    logic [7:0] stage1;
    logic [7:0] stage2;
    logic [7:0] stage4;

    // sign fill only on arithmetic right shifts
    assign fill = ctrl.arith & ~ctrl.left & ctrl.din[7];

    always_comb begin
        if (!ctrl.shamt[0]) begin
            stage1 = ctrl.din;
        end else if (ctrl.left) begin
            stage1 = {ctrl.din[6:0], 1'b0};
        end else begin
            stage1 = {fill, ctrl.din[7:1]};
        end

        if (!ctrl.shamt[1]) begin
            stage2 = stage1;
        end else if (ctrl.left) begin
            stage2 = {stage1[5:0], 2'b00};
        end else begin
            stage2 = {{2{fill}}, stage1[7:2]};
        end

        if (!ctrl.shamt[2]) begin
            stage4 = stage2;
        end else if (ctrl.left) begin
            stage4 = {stage2[3:0], 4'b0000};
        end else begin
            stage4 = {{4{fill}}, stage2[7:4]};
        end
    end

    assign dout = stage4;

endmodule

`default_nettype wire

// ==== logic/lfsr_random.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lab_params.svh"

module lfsr_random (
    input  wire        btn,
    input  wire        reset,
    input  wire        advance,
    output logic [7:0] state
);

    logic feedback;

    // taps at 4, 3, 2 and 0
    assign feedback = state[4] ^ state[3] ^ state[2] ^ state[0];

    always_ff @(posedge btn) begin
        if (reset) begin
            state <= 8'h00;
        end else if (advance) begin
            if (|state) begin
                state <= {feedback, state[7:1]};
            end else begin
                // all-zero is a lockup state
                state <= `LAB_LFSR_SEED;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/ps2_keyboard.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lab_params.svh"

module ps2_keyboard #(
    parameter int fifo_depth = `LAB_KBD_FIFO_DEPTH
) (
    input  wire                  btn,
    input  wire                  reset,
    input  wire                  ps2_clk,
    input  wire                  ps2_data,
    input  wire                  pop,
    output lab_pkg::kbd_status_t status
);

    localparam int ptr_w = $clog2(fifo_depth);

    logic [2:0]       clk_sync;
    logic             clk_fall;
    logic [9:0]       frame;
    logic [3:0]       bit_cnt;
    logic             frame_done;
    logic             frame_ok;
    logic [7:0]       fifo_mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   fifo_count;
    logic             full;
    logic             do_push;
    logic             do_pop;
    logic             overflow;

    // newest sample in bit 0
    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    // stop bit arrives on the eleventh edge
    assign frame_done = clk_fall && (bit_cnt == 4'd10);
    assign frame_ok   = frame_done && !frame[0] && ps2_data && (^frame[9:1]);

    // count only ever reaches fifo_depth, a power of two
    assign full    = fifo_count[ptr_w];
    assign do_push = frame_ok && !full;
    assign do_pop  = pop && (fifo_count != '0);

    always_ff @(posedge btn) begin
        if (reset) begin
            clk_sync <= 3'b111;
            bit_cnt  <= 4'd0;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            if (frame_done) begin
                bit_cnt <= 4'd0;
            end else if (clk_fall) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // start, data lsb first, parity
    always_ff @(posedge btn) begin
        if (clk_fall && (bit_cnt != 4'd10)) begin
            frame <= {ps2_data, frame[9:1]};
        end
    end

    always_ff @(posedge btn) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= frame[8:1];
        end
    end

    always_ff @(posedge btn) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            overflow   <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            // sticky until reset
            if (frame_ok && full) begin
                overflow <= 1'b1;
            end
        end
    end

    assign status.data     = fifo_mem[rd_ptr];
    assign status.ready    = (fifo_count != '0);
    assign status.overflow = overflow;

    fifo_count_bounded: assert property (
        @(posedge btn) disable iff (reset) fifo_count <= fifo_depth
    );

    empty_pop_holds_rd_ptr: assert property (
        @(posedge btn) disable iff (reset) (pop && (fifo_count == '0)) |=> $stable(rd_ptr)
    );

endmodule

`default_nettype wire

// ==== logic/seg_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lab_params.svh"

module seg_decoder (
    input  wire [3:0]  num,
    input  wire        blank,
    output logic [7:0] led
);

    logic [7:0] pattern;

    // bits are a..g then dp, low lights the segment
    always_comb begin
        case (num)
            4'h0:    pattern = 8'b00000011;
            4'h1:    pattern = 8'b10011111;
            4'h2:    pattern = 8'b00100101;
            4'h3:    pattern = 8'b00001101;
            4'h4:    pattern = 8'b10011001;
            4'h5:    pattern = 8'b01001001;
            4'h6:    pattern = 8'b01000001;
            4'h7:    pattern = 8'b00011111;
            4'h8:    pattern = 8'b00000001;
            4'h9:    pattern = 8'b00001001;
            4'ha:    pattern = 8'b00010001;
            4'hb:    pattern = 8'b11000001;
            4'hc:    pattern = 8'b01100011;
            4'hd:    pattern = 8'b10000101;
            4'he:    pattern = 8'b01100001;
            default: pattern = 8'b01110001;
        endcase
    end

    assign led = blank ? `LAB_SEG_BLANK : pattern;

endmodule

`default_nettype wire

// ==== logic/lab_board.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lab_params.svh"

module lab_board (
    input  wire                    btn,
    input  wire                    reset,
    input  wire [15:0]             sw,
    input  wire lab_pkg::lab_mode_e mode,
    input  wire                    step,
    input  wire                    ps2_clk,
    input  wire                    ps2_data,
    output logic [15:0]            ledr,
    output lab_pkg::seg_bank_t     seg
);

    lab_pkg::alu_result_t  alu_res;
    lab_pkg::shift_ctrl_t  shift_ctrl;
    lab_pkg::kbd_status_t  kbd_status;
    logic [7:0]            shift_out;
    logic [7:0]            rand_state;
    logic                  step_q;
    logic                  step_pulse;
    logic                  kbd_pop;
    logic [7:0]            release_cnt;
    logic [15:0]           ledr_next;
    logic [7:0][3:0]       digit_num;
    logic [7:0]            digit_blank;
    logic [7:0][7:0]       digit_led;

    assign shift_ctrl = '{din: sw[7:0], shamt: sw[15:13], left: sw[12], arith: sw[11]};

    lab_alu i_lab_alu (
        .a      (sw[3:0]),
        .b      (sw[7:4]),
        .op     (lab_pkg::alu_op_e'(sw[10:8])),
        .result (alu_res)
    );

    barrel_shifter i_barrel_shifter (
        .ctrl (shift_ctrl),
        .dout (shift_out)
    );

    // rising edge of the button level
    assign step_pulse = step & ~step_q;
    assign kbd_pop    = step_pulse && (mode == lab_pkg::mode_keyboard);

    lfsr_random i_lfsr_random (
        .btn     (btn),
        .reset   (reset),
        .advance (step_pulse),
        .state   (rand_state)
    );

    ps2_keyboard #(
        .fifo_depth (`LAB_KBD_FIFO_DEPTH)
    ) i_ps2_keyboard (
        .btn      (btn),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .pop      (kbd_pop),
        .status   (kbd_status)
    );

    always_ff @(posedge btn) begin
        if (reset) begin
            step_q      <= 1'b0;
            release_cnt <= 8'd0;
        end else begin
            step_q <= step;
            // count release prefixes as they leave the FIFO
            if (kbd_pop && kbd_status.ready && (kbd_status.data == `LAB_BREAK_CODE)) begin
                release_cnt <= release_cnt + 8'd1;
            end
        end
    end

    always_comb begin
        ledr_next   = 16'd0;
        digit_num   = '0;
        digit_blank = 8'hff;
        case (mode)
            lab_pkg::mode_alu: begin
                ledr_next      = {9'd0, alu_res.carry, alu_res.ovfl, alu_res.zero, alu_res.res};
                digit_num[0]   = alu_res.res;
                digit_blank[0] = 1'b0;
            end
            lab_pkg::mode_shift: begin
                ledr_next        = {8'd0, shift_out};
                digit_num[1:0]   = shift_out;
                digit_blank[1:0] = 2'b00;
            end
            lab_pkg::mode_random: begin
                ledr_next        = {8'd0, rand_state};
                digit_num[1:0]   = rand_state;
                digit_blank[1:0] = 2'b00;
            end
            default: begin
                ledr_next        = {6'd0, kbd_status.overflow, kbd_status.ready, kbd_status.data};
                digit_num[1:0]   = kbd_status.data;
                digit_num[7:6]   = release_cnt;
                digit_blank[1:0] = 2'b00;
                digit_blank[7:6] = 2'b00;
            end
        endcase
    end

    for (genvar i = 0; i < 8; i++) begin : g_digit
        seg_decoder i_seg_decoder (
            .num   (digit_num[i]),
            .blank (digit_blank[i]),
            .led   (digit_led[i])
        );
    end

    // one cycle of output latency
    always_ff @(posedge btn) begin
        if (reset) begin
            ledr <= 16'd0;
            seg  <= {8{`LAB_SEG_BLANK}};
        end else begin
            ledr <= ledr_next;
            seg  <= lab_pkg::seg_bank_t'(digit_led);
        end
    end

endmodule

`default_nettype wire

// ==== verification/lab_model.svh ====
`ifndef LAB_MODEL_SVH
`define LAB_MODEL_SVH

`include "lab_params.svh"

function automatic lab_pkg::alu_result_t model_alu(input logic [3:0] a, input logic [3:0] b,
                                                   input lab_pkg::alu_op_e op);
    lab_pkg::alu_result_t r;
    int sa;
    int sb;
    int sr;
    sa = $signed(a);
    sb = $signed(b);
    sr = 0;
    r = '0;
    case (op)
        lab_pkg::op_add: begin
            r.res = a + b;
            r.carry = (int'(a) + int'(b)) > 15;
            sr = sa + sb;
            r.ovfl = (sr > 7) || (sr < -8);
        end
        lab_pkg::op_sub: begin
            r.res = a - b;
            // borrow out of the top bit
            r.carry = a < b;
            sr = sa - sb;
            r.ovfl = (sr > 7) || (sr < -8);
        end
        lab_pkg::op_not: r.res = ~a;
        lab_pkg::op_and: r.res = a & b;
        lab_pkg::op_or: r.res = a | b;
        lab_pkg::op_xor: r.res = a ^ b;
        lab_pkg::op_less: r.res = (sa < sb) ? 4'd1 : 4'd0;
        default: r.res = (a == b) ? 4'd1 : 4'd0;
    endcase
    r.zero = (r.res == 4'd0);
    return r;
endfunction

function automatic logic [7:0] model_shift(input lab_pkg::shift_ctrl_t c);
    if (c.left) begin
        return c.din << c.shamt;
    end else if (c.arith) begin
        return $signed(c.din) >>> c.shamt;
    end
    return c.din >> c.shamt;
endfunction

function automatic logic [7:0] model_lfsr(input logic [7:0] s);
    if (s == 8'h00) begin
        return `LAB_LFSR_SEED;
    end
    return {s[4] ^ s[3] ^ s[2] ^ s[0], s[7:1]};
endfunction

// lit segments a..g, turned into the active-low pattern with dp off
function automatic logic [7:0] seg_pattern(input logic [3:0] num);
    logic [6:0] on;
    case (num)
        4'h0: on = 7'b1111110;
        4'h1: on = 7'b0110000;
        4'h2: on = 7'b1101101;
        4'h3: on = 7'b1111001;
        4'h4: on = 7'b0110011;
        4'h5: on = 7'b1011011;
        4'h6: on = 7'b1011111;
        4'h7: on = 7'b1110000;
        4'h8: on = 7'b1111111;
        4'h9: on = 7'b1111011;
        4'ha: on = 7'b1110111;
        4'hb: on = 7'b0011111;
        4'hc: on = 7'b1001110;
        4'hd: on = 7'b0111101;
        4'he: on = 7'b1001111;
        default: on = 7'b1000111;
    endcase
    return {~on, 1'b1};
endfunction

function automatic lab_pkg::seg_bank_t seg_bank(input logic [7:0][3:0] nums,
                                                input logic [7:0] lit);
    logic [7:0][7:0] digits;
    for (int i = 0; i < 8; i++) begin
        digits[i] = lit[i] ? seg_pattern(nums[i]) : `LAB_SEG_BLANK;
    end
    return lab_pkg::seg_bank_t'(digits);
endfunction

// stop, odd parity, data, start; sent from bit 0 up
function automatic logic [10:0] ps2_frame(input logic [7:0] code, input bit bad_parity);
    return {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
endfunction

`endif

// ==== verification/lab_board_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lab_params.svh"

module lab_board_tb;

    `include "lab_model.svh"

    localparam int bit_cycles = 6;
    localparam int frame_cycles = 11 * bit_cycles + 8;
    localparam int est_cycles = 16 + 200 + 200 + 150 * 6 + 30 * (frame_cycles + 4)
                                + 9 * frame_cycles + 8 * 4;
    localparam int cycle_limit = 4 * est_cycles;

    logic                 btn;
    logic                 reset;
    logic [15:0]          sw;
    lab_pkg::lab_mode_e   mode;
    logic                 step;
    logic                 ps2_clk;
    logic                 ps2_data;
    logic [15:0]          ledr;
    lab_pkg::seg_bank_t   seg;

    int                   cycles;
    int                   checks;
    int                   errors;
    logic [7:0]           lfsr_exp;
    logic [7:0]           rel_exp;
    logic                 ovf_exp;
    logic [7:0]           kbd_q[$];

    lab_board i_lab_board (
        .btn      (btn),
        .reset    (reset),
        .sw       (sw),
        .mode     (mode),
        .step     (step),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .ledr     (ledr),
        .seg      (seg)
    );

    initial begin
        btn = 1'b0;
        forever #10 btn = ~btn;
    end

    always @(posedge btn) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge btn);
        #2;
    endtask

    task automatic check_leds(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: ledr expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_segs(input string name, input lab_pkg::seg_bank_t exp,
                              input lab_pkg::seg_bank_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: seg expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_alu(input string name, input lab_pkg::alu_result_t exp,
                             input lab_pkg::alu_result_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: alu expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic press_step(input lab_pkg::lab_mode_e m);
        mode = m;
        step = 1'b1;
        next_cycle();
        step = 1'b0;
        lfsr_exp = model_lfsr(lfsr_exp);
        if (m == lab_pkg::mode_keyboard && kbd_q.size() > 0) begin
            if (kbd_q[0] == `LAB_BREAK_CODE) begin
                rel_exp++;
            end
            void'(kbd_q.pop_front());
        end
    endtask

    task automatic send_frame(input logic [7:0] code, input bit bad_parity);
        logic [10:0] frame;
        frame = ps2_frame(code, bad_parity);
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            next_cycle();
            ps2_clk = 1'b0;
            repeat (3) next_cycle();
            ps2_clk = 1'b1;
            repeat (2) next_cycle();
        end
        ps2_data = 1'b1;
        // synchronizer and edge detect margin
        repeat (6) next_cycle();
        if (!bad_parity && kbd_q.size() < `LAB_KBD_FIFO_DEPTH) begin
            kbd_q.push_back(code);
        end else if (!bad_parity) begin
            ovf_exp = 1'b1;
        end
    endtask

    task automatic check_keyboard(input string name);
        if (kbd_q.size() > 0) begin
            check_leds(name, {6'd0, ovf_exp, 1'b1, kbd_q[0]}, ledr);
            check_segs(name, seg_bank({rel_exp, 16'h0000, kbd_q[0]}, 8'hc3), seg);
        end else begin
            // head data of an empty FIFO is not defined, digits 0 and 1 masked
            check_leds(name, {6'd0, ovf_exp, 1'b0, 8'h00}, ledr & 16'hff00);
            check_segs(name, seg_bank({rel_exp, 24'd0}, 8'hc0), seg | 64'hffff);
        end
    endtask

    initial begin
        lab_pkg::alu_result_t alu_exp;
        lab_pkg::shift_ctrl_t sh;
        logic [7:0] r;
        logic [7:0] code;
        bit bad;
        int err0;
        void'($urandom(32'hdf40b6ee));
        cycles = 0;
        checks = 0;
        errors = 0;
        lfsr_exp = 8'h00;
        rel_exp = 8'h00;
        ovf_exp = 1'b0;
        reset = 1'b1;
        sw = 16'h0000;
        mode = lab_pkg::mode_alu;
        step = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;

        err0 = errors;
        for (int i = 0; i < 16; i++) begin
            mode = lab_pkg::lab_mode_e'(i % 4);
            next_cycle();
            check_leds("reset", 16'h0000, ledr);
            check_segs("reset", seg_bank('0, 8'h00), seg);
        end
        reset = 1'b0;
        press_step(lab_pkg::mode_random);
        next_cycle();
        check_leds("reset", {8'd0, lfsr_exp}, ledr);
        check_segs("reset", seg_bank({24'd0, lfsr_exp}, 8'h03), seg);
        report_test("reset", err0);

        err0 = errors;
        mode = lab_pkg::mode_alu;
        for (int i = 0; i < 200; i++) begin
            sw = 16'($urandom);
            next_cycle();
            alu_exp = model_alu(sw[3:0], sw[7:4], lab_pkg::alu_op_e'(sw[10:8]));
            check_alu("alu", alu_exp,
                      '{res: ledr[3:0], zero: ledr[4], ovfl: ledr[5], carry: ledr[6]});
            check_leds("alu", {9'd0, alu_exp.carry, alu_exp.ovfl, alu_exp.zero, alu_exp.res},
                       ledr);
            check_segs("alu", seg_bank({28'd0, alu_exp.res}, 8'h01), seg);
        end
        report_test("alu", err0);

        err0 = errors;
        mode = lab_pkg::mode_shift;
        for (int i = 0; i < 200; i++) begin
            sw = 16'($urandom);
            next_cycle();
            sh = '{din: sw[7:0], shamt: sw[15:13], left: sw[12], arith: sw[11]};
            r = model_shift(sh);
            check_leds("shift", {8'd0, r}, ledr);
            check_segs("shift", seg_bank({24'd0, r}, 8'h03), seg);
        end
        report_test("shift", err0);

        err0 = errors;
        for (int i = 0; i < 150; i++) begin
            // FIFO is empty here, so keyboard mode steps pop nothing
            press_step(lab_pkg::lab_mode_e'($urandom_range(0, 3)));
            mode = lab_pkg::mode_random;
            next_cycle();
            check_leds("random", {8'd0, lfsr_exp}, ledr);
            check_segs("random", seg_bank({24'd0, lfsr_exp}, 8'h03), seg);
            repeat ($urandom_range(0, 3)) next_cycle();
        end
        report_test("random", err0);

        err0 = errors;
        mode = lab_pkg::mode_keyboard;
        for (int i = 0; i < 30; i++) begin
            code = ($urandom_range(0, 4) == 0) ? `LAB_BREAK_CODE : 8'($urandom);
            bad = ($urandom_range(0, 5) == 0);
            send_frame(code, bad);
            check_keyboard("keyboard");
            if (kbd_q.size() > 0) begin
                press_step(lab_pkg::mode_keyboard);
                repeat (2) next_cycle();
                check_keyboard("keyboard");
            end
        end
        report_test("keyboard", err0);

        err0 = errors;
        for (int i = 0; i < 9; i++) begin
            code = ($urandom_range(0, 3) == 0) ? `LAB_BREAK_CODE : 8'($urandom);
            send_frame(code, 1'b0);
        end
        check_keyboard("overflow");
        for (int i = 0; i < 8; i++) begin
            press_step(lab_pkg::mode_keyboard);
            repeat (2) next_cycle();
            check_keyboard("overflow");
        end
        report_test("overflow", err0);

        $display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
+incdir+verification
logic/lab_pkg.sv
logic/lab_alu.sv
logic/barrel_shifter.sv
logic/lfsr_random.sv
logic/ps2_keyboard.sv
logic/seg_decoder.sv
logic/lab_board.sv
verification/lab_board_tb.sv
